// File: blit_types_pkg.sv
// shared types of the blitter, word fixed at 16 bits
// lines and words hold the count minus one
`default_nettype none

package blit_types_pkg;

    typedef logic [15:0] word_t;         // VRAM data word
    typedef logic [15:0] addr_t;         // VRAM word address
    typedef logic [3:0]  nibble_mask_t;  // one bit per nibble
    typedef logic [1:0]  shift_t;        // right shift in nibbles
    typedef logic [7:0]  transp_t;       // transparency value
    typedef logic [16:0] count_t;        // top bit is the underflow flag

    // one complete blit setup
    typedef struct packed {
        logic         s_const;       // source from src_s, no reads
        logic         transp_en;
        logic         transp_8b;
        transp_t      transp_value;
        shift_t       shift_amount;
        nibble_mask_t first_mask;    // first word of each line
        nibble_mask_t last_mask;     // last word of each line
        word_t        mod_s;
        word_t        src_s;         // source address or constant
        word_t        and_c;
        word_t        xor_c;
        word_t        mod_d;
        word_t        dst_d;
        word_t        lines;
        word_t        words;
    } blit_cfg_t;

    typedef enum logic [2:0] {
        IDLE,        // wait for a queued blit
        SETUP,       // take the queued set
        LINE_BEG,    // load counters, first access
        RD_S,        // source read
        WR_D,        // destination write
        LINE_END     // add modulos, next line or done
    } blit_state_t;

endpackage

`default_nettype wire

// File: blit_regmap_pkg.sv
// register numbers and bit fields seen by the host
// unused register numbers are ignored on write
`default_nettype none

package blit_regmap_pkg;

    localparam logic [3:0] REG_CTRL  = 4'd0;
    localparam logic [3:0] REG_AND_C = 4'd1;
    localparam logic [3:0] REG_XOR_C = 4'd2;
    localparam logic [3:0] REG_MOD_S = 4'd3;
    localparam logic [3:0] REG_SRC_S = 4'd4;
    localparam logic [3:0] REG_MOD_D = 4'd5;
    localparam logic [3:0] REG_DST_D = 4'd6;
    localparam logic [3:0] REG_SHIFT = 4'd7;
    localparam logic [3:0] REG_LINES = 4'd8;
    localparam logic [3:0] REG_WORDS = 4'd9;  // write queues the blit

    // CTRL fields
    localparam int CTRL_TVAL_MSB   = 15;
    localparam int CTRL_TVAL_LSB   = 8;
    localparam int CTRL_T8B_BIT    = 5;       // 8-bit transparency
    localparam int CTRL_TEN_BIT    = 4;       // transparency enable
    localparam int CTRL_SCONST_BIT = 0;       // source is constant

    // SHIFT fields
    localparam int SHIFT_FMASK_MSB = 15;
    localparam int SHIFT_FMASK_LSB = 12;
    localparam int SHIFT_LMASK_MSB = 11;
    localparam int SHIFT_LMASK_LSB = 8;
    localparam int SHIFT_AMT_MSB   = 1;
    localparam int SHIFT_AMT_LSB   = 0;

endpackage

`default_nettype wire

// File: blit_regs.sv
// write-only register set holding one queued blit
// a write to REG_WORDS queues the blit, setup moves it to the active set
`default_nettype none
`timescale 1ns/1ps

module blit_regs (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      reg_wr_i,
    input  wire logic [3:0]                reg_num_i,
    input  wire blit_types_pkg::word_t     reg_data_i,
    input  wire logic                      setup_i,
    output      blit_types_pkg::blit_cfg_t active_cfg_o,
    output      logic                      queued_o
);
    import blit_types_pkg::*;
    import blit_regmap_pkg::*;

    blit_cfg_t queued_cfg;          // set being written by the host

    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_cfg   <= '0;
            active_cfg_o <= '0;
            queued_o     <= 1'b0;
        end else begin
            if (setup_i) begin
                active_cfg_o <= queued_cfg;     // old values, same-cycle write goes to queue
                queued_o     <= 1'b0;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_CTRL: begin
                        queued_cfg.transp_value <= reg_data_i[CTRL_TVAL_MSB:CTRL_TVAL_LSB];
                        queued_cfg.transp_8b    <= reg_data_i[CTRL_T8B_BIT];
                        queued_cfg.transp_en    <= reg_data_i[CTRL_TEN_BIT];
                        queued_cfg.s_const      <= reg_data_i[CTRL_SCONST_BIT];
                    end
                    REG_AND_C: begin
                        queued_cfg.and_c <= reg_data_i;
                    end
                    REG_XOR_C: begin
                        queued_cfg.xor_c <= reg_data_i;
                    end
                    REG_MOD_S: begin
                        queued_cfg.mod_s <= reg_data_i;
                    end
                    REG_SRC_S: begin
                        queued_cfg.src_s <= reg_data_i;
                    end
                    REG_MOD_D: begin
                        queued_cfg.mod_d <= reg_data_i;
                    end
                    REG_DST_D: begin
                        queued_cfg.dst_d <= reg_data_i;
                    end
                    REG_SHIFT: begin
                        queued_cfg.first_mask   <= reg_data_i[SHIFT_FMASK_MSB:SHIFT_FMASK_LSB];
                        queued_cfg.last_mask    <= reg_data_i[SHIFT_LMASK_MSB:SHIFT_LMASK_LSB];
                        queued_cfg.shift_amount <= reg_data_i[SHIFT_AMT_MSB:SHIFT_AMT_LSB];
                    end
                    REG_LINES: begin
                        queued_cfg.lines <= reg_data_i;
                    end
                    REG_WORDS: begin
                        queued_cfg.words <= reg_data_i;
                        queued_o         <= 1'b1;   // wins over setup clear
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // the sequencer may only take a blit that is really queued
    setup_needs_queue: assert property (
        @(posedge clk) disable iff (reset_i)
        setup_i |-> queued_o
    ) else $error("blit_regs: setup_i while queued_o is low");

endmodule

`default_nettype wire

// File: blit_sequencer.sv
// blit state machine with the VRAM address, select and write strobes
// outputs hold until ack, the state only moves when sel is low or ack high
`default_nettype none
`timescale 1ns/1ps

module blit_sequencer (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire blit_types_pkg::blit_cfg_t    cfg_i,
    input  wire logic                         queued_i,
    input  wire logic                         vram_ack_i,
    output      logic                         setup_o,
    output      logic                         capture_o,
    output      logic                         line_first_o,
    output      blit_types_pkg::nibble_mask_t edge_mask_o,
    output      logic                         vram_sel_o,
    output      logic                         vram_wr_o,
    output      blit_types_pkg::addr_t        vram_addr_o,
    output      logic                         busy_o,
    output      logic                         done_o
);
    import blit_types_pkg::*;

    blit_state_t state_q, state_d;
    logic        sel_q, sel_d;
    logic        wr_q, wr_d;
    addr_t       addr_q, addr_d;
    addr_t       src_q, src_d;          // running source address
    addr_t       dst_q, dst_d;          // running destination address
    count_t      lines_q, lines_d;
    count_t      count_q, count_d;      // words left in this line
    logic        first_q, first_d;      // first word of the line
    logic        done_q, done_d;
    logic        new_blit_q;            // first LINE_BEG after setup
    logic        busy_q;
    logic        advance;
    logic        last_word;
    logic        last_line;
    addr_t       src_base;
    addr_t       dst_base;
    count_t      lines_base;

    assign advance    = !sel_q || vram_ack_i;
    assign last_word  = count_q[16];            // underflow marks last word
    assign last_line  = lines_q[16];
    assign src_base   = new_blit_q ? cfg_i.src_s : src_q;
    assign dst_base   = new_blit_q ? cfg_i.dst_d : dst_q;
    assign lines_base = new_blit_q ? {1'b0, cfg_i.lines} : lines_q;

    assign setup_o      = (state_q == SETUP);
    assign capture_o    = (state_q == RD_S);    // pixel path samples on ack
    assign line_first_o = first_q;
    assign edge_mask_o  = (first_q   ? cfg_i.first_mask : 4'b1111) &
                          (last_word ? cfg_i.last_mask  : 4'b1111);
    assign vram_sel_o   = sel_q;
    assign vram_wr_o    = wr_q;
    assign vram_addr_o  = addr_q;
    assign busy_o       = busy_q;
    assign done_o       = done_q;

    always_comb begin
        state_d = state_q;
        sel_d   = 1'b0;
        wr_d    = 1'b0;
        addr_d  = addr_q;
        src_d   = src_q;
        dst_d   = dst_q;
        lines_d = lines_q;
        count_d = count_q;
        first_d = first_q;
        done_d  = 1'b0;

        case (state_q)
            IDLE: begin
                if (queued_i) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                state_d = LINE_BEG;             // active set valid next cycle
            end
            LINE_BEG: begin
                lines_d = lines_base - 1'b1;    // pre-decrement
                count_d = {1'b0, cfg_i.words} - 1'b1;
                first_d = 1'b1;
                src_d   = src_base;
                dst_d   = dst_base;
                sel_d   = 1'b1;
                if (!cfg_i.s_const) begin
                    addr_d  = src_base;
                    state_d = RD_S;
                end else begin
                    wr_d    = 1'b1;
                    addr_d  = dst_base;
                    state_d = WR_D;
                end
            end
            RD_S: begin
                src_d   = addr_q + 1'b1;
                sel_d   = 1'b1;
                wr_d    = 1'b1;
                addr_d  = dst_q;
                state_d = WR_D;
            end
            WR_D: begin
                dst_d   = addr_q + 1'b1;
                count_d = count_q - 1'b1;
                first_d = 1'b0;
                if (last_word) begin
                    state_d = LINE_END;
                end else if (!cfg_i.s_const) begin
                    sel_d   = 1'b1;
                    addr_d  = src_q;
                    state_d = RD_S;
                end else begin
                    sel_d   = 1'b1;             // back-to-back constant writes
                    wr_d    = 1'b1;
                    addr_d  = addr_q + 1'b1;
                    state_d = WR_D;
                end
            end
            LINE_END: begin
                src_d = src_q + cfg_i.mod_s;
                dst_d = dst_q + cfg_i.mod_d;
                if (last_line) begin
                    done_d  = 1'b1;
                    state_d = queued_i ? SETUP : IDLE;
                end else begin
                    state_d = LINE_BEG;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            sel_q      <= 1'b0;
            wr_q       <= 1'b0;
            addr_q     <= '0;
            src_q      <= '0;
            dst_q      <= '0;
            lines_q    <= '0;
            count_q    <= '0;
            first_q    <= 1'b0;
            done_q     <= 1'b0;
            new_blit_q <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            if (advance) begin
                state_q    <= state_d;
                sel_q      <= sel_d;
                wr_q       <= wr_d;
                addr_q     <= addr_d;
                src_q      <= src_d;
                dst_q      <= dst_d;
                lines_q    <= lines_d;
                count_q    <= count_d;
                first_q    <= first_d;
                done_q     <= done_d;
                new_blit_q <= (state_q == SETUP);
            end
            busy_q <= (state_q != IDLE);        // one cycle behind the state
        end
    end

    // a pending access keeps its address and direction until ack
    access_held: assert property (
        @(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_ack_i) |=>
            (vram_sel_o && $stable(vram_addr_o) && $stable(vram_wr_o))
    ) else $error("blit_sequencer: VRAM access changed before ack");

endmodule

`default_nettype wire

// File: blit_pixel_path.sv
// source capture, nibble shift, logic op and transparency
// the shift carries nibbles from the previous read of the same line only
`default_nettype none
`timescale 1ns/1ps

module blit_pixel_path (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire blit_types_pkg::blit_cfg_t    cfg_i,
    input  wire logic                         capture_i,
    input  wire logic                         vram_ack_i,
    input  wire logic                         line_first_i,
    input  wire blit_types_pkg::nibble_mask_t edge_mask_i,
    input  wire blit_types_pkg::word_t        vram_data_i,
    output      blit_types_pkg::word_t        vram_data_o,
    output      blit_types_pkg::nibble_mask_t vram_wr_mask_o
);
    import blit_types_pkg::*;

    word_t        src_word_q;       // shifted source from the last read
    logic [11:0]  prev_q;           // low nibbles of the last read
    logic [11:0]  carry;
    word_t        src_word;
    word_t        val_sca;
    nibble_mask_t t4_mask;
    nibble_mask_t t8_mask;

    function automatic word_t shift_in(input shift_t amount, input word_t data,
                                       input logic [11:0] prev);
        word_t result;
        case (amount)
            2'd0:    result = data;
            2'd1:    result = {prev[3:0], data[15:4]};
            2'd2:    result = {prev[7:0], data[15:8]};
            default: result = {prev[11:0], data[15:12]};
        endcase
        return result;
    endfunction

    assign carry = line_first_i ? 12'h000 : prev_q;     // nothing carried into a new line

    always_ff @(posedge clk) begin
        if (reset_i) begin
            src_word_q <= '0;
            prev_q     <= '0;
        end else if (capture_i && vram_ack_i) begin
            src_word_q <= shift_in(cfg_i.shift_amount, vram_data_i, carry);
            prev_q     <= vram_data_i[11:0];
        end
    end

    assign src_word    = cfg_i.s_const ? cfg_i.src_s : src_word_q;
    assign val_sca     = src_word & ~cfg_i.and_c;
    assign vram_data_o = val_sca ^ cfg_i.xor_c;

    // 4-bit mode, odd nibbles against the high half of the value
    assign t4_mask = {
        !cfg_i.transp_en || (val_sca[15:12] != cfg_i.transp_value[7:4]),
        !cfg_i.transp_en || (val_sca[11:8]  != cfg_i.transp_value[3:0]),
        !cfg_i.transp_en || (val_sca[7:4]   != cfg_i.transp_value[7:4]),
        !cfg_i.transp_en || (val_sca[3:0]   != cfg_i.transp_value[3:0])
    };

    // 8-bit mode, both nibbles of a byte follow that byte
    assign t8_mask = {
        {2{!cfg_i.transp_en || (val_sca[15:8] != cfg_i.transp_value)}},
        {2{!cfg_i.transp_en || (val_sca[7:0]  != cfg_i.transp_value)}}
    };

    assign vram_wr_mask_o = edge_mask_i & (cfg_i.transp_8b ? t8_mask : t4_mask);

endmodule

`default_nettype wire

// File: blitter.sv
// blitter top level, one active blit and one queued
// VRAM port stalls on sel until ack, read data valid in the ack cycle
`default_nettype none
`timescale 1ns/1ps

module blitter (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire logic                         reg_wr_i,
    input  wire logic [3:0]                   reg_num_i,
    input  wire blit_types_pkg::word_t        reg_data_i,
    output      logic                         busy_o,
    output      logic                         full_o,
    output      logic                         done_o,
    output      logic                         vram_sel_o,
    input  wire logic                         vram_ack_i,
    output      logic                         vram_wr_o,
    output      blit_types_pkg::nibble_mask_t vram_wr_mask_o,
    output      blit_types_pkg::addr_t        vram_addr_o,
    input  wire blit_types_pkg::word_t        vram_data_i,
    output      blit_types_pkg::word_t        vram_data_o
);
    import blit_types_pkg::*;

    blit_cfg_t    active_cfg;
    logic         setup;
    logic         capture;
    logic         line_first;
    nibble_mask_t edge_mask;

    blit_regs regs_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .setup_i      (setup),
        .active_cfg_o (active_cfg),
        .queued_o     (full_o)          // queue full is the queued flag
    );

    blit_sequencer seq_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (active_cfg),
        .queued_i     (full_o),
        .vram_ack_i   (vram_ack_i),
        .setup_o      (setup),
        .capture_o    (capture),
        .line_first_o (line_first),
        .edge_mask_o  (edge_mask),
        .vram_sel_o   (vram_sel_o),
        .vram_wr_o    (vram_wr_o),
        .vram_addr_o  (vram_addr_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    blit_pixel_path pix_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (active_cfg),
        .capture_i      (capture),
        .vram_ack_i     (vram_ack_i),
        .line_first_i   (line_first),
        .edge_mask_i    (edge_mask),
        .vram_data_i    (vram_data_i),
        .vram_data_o    (vram_data_o),
        .vram_wr_mask_o (vram_wr_mask_o)
    );

endmodule

`default_nettype wire

// File: tb_blitter.sv
// testbench for the blitter with a 64K word VRAM model and random ack delay
// expected VRAM contents are built from the blit rules when each blit is issued
`default_nettype none
`timescale 1ns/1ps

module tb_blitter;
    import blit_types_pkg::*;
    import blit_regmap_pkg::*;

    logic         clk;
    logic         reset_i;
    logic         reg_wr_i;
    logic [3:0]   reg_num_i;
    word_t        reg_data_i;
    logic         busy_o;
    logic         full_o;
    logic         done_o;
    logic         vram_sel_o;
    logic         vram_ack_i = 1'b0;
    logic         vram_wr_o;
    nibble_mask_t vram_wr_mask_o;
    addr_t        vram_addr_o;
    word_t        vram_data_i;
    word_t        vram_data_o;

    word_t  mem [0:65535];          // VRAM model
    word_t  shadow [0:65535];       // expected VRAM contents
    word_t  wr_merged;              // VRAM word after the pending write
    word_t  wr_expect;
    integer seed = 64554;
    logic   rand_delay = 1'b0;
    logic   pending = 1'b0;         // access seen, ack not yet given
    int     wait_left = 0;
    logic   fill_run = 1'b0;        // constant fill running, no reads allowed
    logic   queue_run = 1'b0;
    int     done_seen = 0;
    int     blits_issued = 0;
    int     value_errors = 0;
    int     proto_errors = 0;
    int     timeouts = 0;

    blitter dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .busy_o         (busy_o),
        .full_o         (full_o),
        .done_o         (done_o),
        .vram_sel_o     (vram_sel_o),
        .vram_ack_i     (vram_ack_i),
        .vram_wr_o      (vram_wr_o),
        .vram_wr_mask_o (vram_wr_mask_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_i    (vram_data_i),
        .vram_data_o    (vram_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign vram_data_i = mem[vram_addr_o];      // read data valid while addressed

    always_comb begin
        wr_merged = mem[vram_addr_o];
        for (int n = 0; n < 4; n++) begin
            if (vram_wr_mask_o[n]) begin
                wr_merged[4*n +: 4] = vram_data_o[4*n +: 4];
            end
        end
        wr_expect = shadow[vram_addr_o];
    end

    always @(posedge clk) begin
        if (vram_sel_o && vram_wr_o && vram_ack_i) begin
            mem[vram_addr_o] <= wr_merged;      // write lands in the ack cycle
        end
        if (done_o) begin
            done_seen <= done_seen + 1;
        end
        if (queue_run && done_seen < blits_issued) begin
            assert (busy_o) else begin
                proto_errors++;
                $display("busy dropped at t=%0t while a queued blit was pending", $time);
            end
        end
    end

    // ack after 0 to 3 cycles, a new access may start right after an ack
    always @(posedge clk) begin
        #1;
        if (reset_i) begin
            vram_ack_i = 1'b0;
            pending    = 1'b0;
        end else begin
            if (vram_ack_i) begin
                pending = 1'b0;
            end
            vram_ack_i = 1'b0;
            if (vram_sel_o && !pending) begin
                pending   = 1'b1;
                wait_left = rand_delay ? {$random(seed)} % 4 : 0;
            end
            if (pending) begin
                if (wait_left == 0) begin
                    vram_ack_i = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    write_matches: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && vram_wr_o && vram_ack_i) |-> (wr_merged == wr_expect))
        else begin
            value_errors++;
            $display("CHECK FAILED t=%0t vram_data_o at %h: got %h expected %h", $time,
                     $sampled(vram_addr_o), $sampled(wr_merged), $sampled(wr_expect));
        end

    access_stable: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_ack_i) |=>
            (vram_sel_o && $stable(vram_addr_o) && $stable(vram_wr_o)))
        else begin
            proto_errors++;
            $display("VRAM access changed before its ack at t=%0t", $time);
        end

    no_fill_reads: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_wr_o) |-> !fill_run)
        else begin
            proto_errors++;
            $display("constant fill issued a VRAM read at t=%0t", $time);
        end

    full_until_setup: assert property (@(posedge clk) disable iff (reset_i)
        $fell(full_o) |-> $past(dut_i.setup))
        else begin
            proto_errors++;
            $display("queue-full flag fell without a setup at t=%0t", $time);
        end

    done_single: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o)
        else begin
            proto_errors++;
            $display("done stayed high for more than one cycle at t=%0t", $time);
        end

    function automatic blit_cfg_t rect_cfg(input addr_t src, input word_t mod_s, input addr_t dst,
                                           input word_t mod_d, input int nlines, input int nwords);
        blit_cfg_t c;
        c = '0;
        c.first_mask = 4'hF;
        c.last_mask  = 4'hF;
        c.src_s      = src;
        c.mod_s      = mod_s;
        c.dst_d      = dst;
        c.mod_d      = mod_d;
        c.lines      = word_t'(nlines - 1);     // registers hold count minus one
        c.words      = word_t'(nwords - 1);
        return c;
    endfunction

    // expected result of one blit, applied to the shadow memory
    task automatic model_blit(input blit_cfg_t c);
        addr_t        s;
        addr_t        d;
        word_t        prev;
        word_t        cur;
        word_t        v;
        word_t        res;
        nibble_mask_t m;
        s = c.src_s;
        d = c.dst_d;
        for (int l = 0; l <= int'(c.lines); l++) begin
            prev = '0;                          // no carry into a new line
            for (int w = 0; w <= int'(c.words); w++) begin
                if (c.s_const) begin
                    v = c.src_s;
                end else begin
                    cur  = shadow[s];
                    v    = word_t'({prev, cur} >> (4 * int'(c.shift_amount)));
                    prev = cur;
                    s    = s + 16'd1;
                end
                v   = v & ~c.and_c;
                res = v ^ c.xor_c;
                m   = 4'hF;
                if (w == 0) m = m & c.first_mask;
                if (w == int'(c.words)) m = m & c.last_mask;
                for (int n = 0; n < 4; n++) begin
                    if (c.transp_en && c.transp_8b && v[8*(n/2) +: 8] == c.transp_value) begin
                        m[n] = 1'b0;
                    end
                    if (c.transp_en && !c.transp_8b &&
                        v[4*n +: 4] == c.transp_value[4*(n%2) +: 4]) begin
                        m[n] = 1'b0;
                    end
                    if (m[n]) shadow[d][4*n +: 4] = res[4*n +: 4];
                end
                d = d + 16'd1;
            end
            s = s + c.mod_s;
            d = d + c.mod_d;
        end
    endtask

    task automatic write_reg(input logic [3:0] num, input word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    task automatic issue_blit(input blit_cfg_t c);
        model_blit(c);
        write_reg(REG_CTRL, {c.transp_value, 2'b00, c.transp_8b, c.transp_en, 3'b000, c.s_const});
        write_reg(REG_AND_C, c.and_c);
        write_reg(REG_XOR_C, c.xor_c);
        write_reg(REG_MOD_S, c.mod_s);
        write_reg(REG_SRC_S, c.src_s);
        write_reg(REG_MOD_D, c.mod_d);
        write_reg(REG_DST_D, c.dst_d);
        write_reg(REG_SHIFT, {c.first_mask, c.last_mask, 6'd0, c.shift_amount});
        write_reg(REG_LINES, c.lines);
        write_reg(REG_WORDS, c.words);          // queues the blit
        blits_issued++;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_seen < blits_issued && cycles < 4000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (done_seen < blits_issued) begin
            timeouts++;
            $display("timeout while waiting for blit %0d to finish", blits_issued);
        end
    endtask

    task automatic wait_busy(input logic level);
        int cycles;
        cycles = 0;
        while (busy_o !== level && cycles < 200) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy_o !== level) begin
            timeouts++;
            $display("timeout while waiting for busy to become %b", level);
        end
    endtask

    task automatic run_basic(input addr_t base);
        blit_cfg_t c;
        word_t     pattern [4];
        pattern = '{16'h5A5A, 16'h1A52, 16'h5A00, 16'h005A};
        c = rect_cfg(base + 16'h0100, 16'd4, base + 16'h0800, 16'd12, 3, 4);
        c.shift_amount = 2'd1;
        c.first_mask   = 4'b0111;
        c.last_mask    = 4'b1100;
        issue_blit(c);
        wait_done();
        c = rect_cfg(16'hA5C3, 16'd0, base + 16'h1000, 16'd10, 2, 6);
        c.s_const = 1'b1;                       // src_s is the constant
        c.and_c   = 16'h0F00;
        c.xor_c   = 16'h1234;
        fill_run  = 1'b1;
        issue_blit(c);
        wait_done();
        fill_run = 1'b0;
        for (int k = 0; k < 4; k++) begin      // known source words for transparency
            c = rect_cfg(pattern[k], 16'd0, base + 16'h1800 + 16'(k), 16'd0, 1, 1);
            c.s_const = 1'b1;
            issue_blit(c);
            wait_done();
        end
        c = rect_cfg(base + 16'h1800, 16'd0, base + 16'h1900, 16'd6, 2, 2);
        c.transp_en    = 1'b1;
        c.transp_value = 8'h5A;
        c.xor_c        = 16'h0F0F;
        issue_blit(c);
        wait_done();
        c.dst_d     = base + 16'h1A00;
        c.transp_8b = 1'b1;
        issue_blit(c);
        wait_done();
    endtask

    task automatic run_queue(input addr_t base);
        blit_cfg_t a;
        blit_cfg_t b;
        a = rect_cfg(base + 16'h2000, 16'd2, base + 16'h2800, 16'd3, 2, 6);
        a.shift_amount = 2'd3;
        a.first_mask   = 4'b1110;
        a.last_mask    = 4'b0011;
        a.and_c        = 16'h8001;
        b = rect_cfg(base + 16'h3000, 16'd0, base + 16'h3800, 16'd1, 3, 3);
        b.shift_amount = 2'd2;
        b.transp_en    = 1'b1;
        issue_blit(a);
        wait_busy(1'b1);
        queue_run = 1'b1;
        issue_blit(b);                          // waits in the queue behind a
        wait_done();
        queue_run = 1'b0;
        wait_busy(1'b0);
    endtask

    initial begin
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = 4'd0;
        reg_data_i = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a]    = word_t'(a * 40503) ^ word_t'(a >> 7) ^ 16'h3C96;
            shadow[a] = mem[a];
        end
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        run_basic(16'h0000);
        run_queue(16'h0000);
        rand_delay = 1'b1;                      // back-pressure from here on
        run_basic(16'h8000);
        run_queue(16'h8000);
        repeat (4) @(posedge clk);
        for (int a = 0; a < 65536; a++) begin
            assert (mem[a] == shadow[a]) else begin
                value_errors++;
                $display("CHECK FAILED t=%0t mem[%h]: got %h expected %h", $time, a[15:0],
                         mem[a], shadow[a]);
            end
        end
        assert (done_seen == blits_issued) else begin
            proto_errors++;
            $display("done pulsed %0d times for %0d blits", done_seen, blits_issued);
        end
        $display("errors: value %0d, protocol %0d, timeout %0d", value_errors, proto_errors,
                 timeouts);
        if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #1000000;
        $display("simulation ran too long and was stopped");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
blit_types_pkg.sv
blit_regmap_pkg.sv
blit_regs.sv
blit_sequencer.sv
blit_pixel_path.sv
blitter.sv
tb_blitter.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the blitter testbench with Verilator.
# Pass or fail is taken from sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_blitter -f src.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_blitter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
